// File: sources.f
+incdir+.
sb_pkg.sv
issue_port_if.sv
wb_port_if.sv
issue_alloc.sv
regfile_4r2w.sv
scoreboard.sv
operand_status.sv
sb_top.sv
tb_sb_top.sv

// File: Bender.yml
package:
  name: register_scoreboard

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sb_pkg.sv
      - issue_port_if.sv
      - wb_port_if.sv
      - issue_alloc.sv
      - regfile_4r2w.sv
      - scoreboard.sv
      - operand_status.sv
      - sb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sb_top.sv

// File: tb_sb_top.sv
/*
  Directed testbench for the register scoreboard top level.
  Keeps its own model of the issue timer and both boards, drives the
  DUT at the rising edge and compares every lookup port and both issue
  tags at the falling edge. Run with the file list in sources.f.
*/
`timescale 1ns/1ns
`default_nettype none

`include "sb_defs.svh"

module tb_sb_top import sb_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 4;
  // after_reset, issue_pending, timer_wrap, writeback, reg_zero, random_mix
  localparam int TEST_CYCLES = 8 + 2 + 10 + 9 + 2 + 200;
  localparam int MARGIN_CYCLES = 50;

  logic clk;
  logic rst_n;
  reg_addr_t  [`SB_RD_PORTS-1:0] rd_addr_i;
  logic       [`SB_ISSUE_W-1:0]  issue_i;
  reg_addr_t  [`SB_ISSUE_W-1:0]  wr_addr_i;
  issue_tag_t [`SB_ISSUE_W-1:0]  wr_tag_o;
  reg_addr_t  [`SB_ISSUE_W-1:0]  wb_addr_i;
  tid_t       [`SB_ISSUE_W-1:0]  wb_tid_i;
  logic       [`SB_ISSUE_W-1:0]  wb_valid_i;
  issue_tag_t [`SB_RD_PORTS-1:0] rd_tag_o;
  logic       [`SB_RD_PORTS-1:0] rd_ready_o;
  logic       [`SB_RD_PORTS-1:0] rd_fwd_lane_o;

  // stimulus for the next cycle
  reg_addr_t [`SB_RD_PORTS-1:0] stim_ra;
  logic      [`SB_ISSUE_W-1:0]  stim_iss;
  reg_addr_t [`SB_ISSUE_W-1:0]  stim_wa;
  logic      [`SB_ISSUE_W-1:0]  stim_wbv;
  reg_addr_t [`SB_ISSUE_W-1:0]  stim_wba;
  tid_t      [`SB_ISSUE_W-1:0]  stim_wbt;

  // reference model
  issue_tag_t model_issue [`SB_NUM_REGS];
  tid_t model_commit [`SB_NUM_REGS];
  tid_t model_timer;

  int error_count = 0;
  logic [31:0] rng_state = 32'h65d5769c;

  sb_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_addr_i     (rd_addr_i),
    .issue_i       (issue_i),
    .wr_addr_i     (wr_addr_i),
    .wr_tag_o      (wr_tag_o),
    .wb_addr_i     (wb_addr_i),
    .wb_tid_i      (wb_tid_i),
    .wb_valid_i    (wb_valid_i),
    .rd_tag_o      (rd_tag_o),
    .rd_ready_o    (rd_ready_o),
    .rd_fwd_lane_o (rd_fwd_lane_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: the tests did not finish in the expected number of cycles");
    $display("Result: FAILED");
    $finish;
  end

  // xorshift32
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // any register except 0
  function automatic reg_addr_t random_reg();
    return reg_addr_t'(1 + next_random() % 31);
  endfunction

  // timer runs 1..7 and skips 0
  function automatic tid_t next_tid(input tid_t t);
    return (t == tid_t'(7)) ? tid_t'(1) : tid_t'(t + 1);
  endfunction

  task automatic check_tag(input string name, input issue_tag_t exp, input issue_tag_t act);
    if (act !== exp) begin
      error_count++;
      $display("** Error %s: expected tid %0d lane %0d, actual tid %0d lane %0d",
               name, exp.tid, exp.lane, act.tid, act.lane);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic clear_stim();
    stim_ra = '0;
    stim_iss = '0;
    stim_wa = '0;
    stim_wbv = '0;
    stim_wba = '0;
    stim_wbt = '0;
  endtask

  task automatic reset_model();
    for (int i = 0; i < `SB_NUM_REGS; i++) begin
      model_issue[i] = '0;
      model_commit[i] = '0;
    end
    model_timer = tid_t'(1);
  endtask

  // state after the coming edge
  task automatic update_model();
    for (int l = 0; l < `SB_ISSUE_W; l++) begin
      if (issue_i[l] && wr_addr_i[l] != '0) begin
        model_issue[wr_addr_i[l]] = issue_tag_t'{tid: model_timer, lane: 1'(l)};
      end
    end
    for (int p = 0; p < `SB_ISSUE_W; p++) begin
      if (wb_valid_i[p] && wb_addr_i[p] != '0) begin
        model_commit[wb_addr_i[p]] = wb_tid_i[p];
      end
    end
    if (|issue_i) begin
      model_timer = next_tid(model_timer);
    end
  endtask

  task automatic compare_outputs(input string name);
    reg_addr_t a;
    issue_tag_t exp_tag;
    logic exp_ready;
    for (int r = 0; r < `SB_RD_PORTS; r++) begin
      a = rd_addr_i[r];
      exp_tag = model_issue[a];
      exp_ready = (exp_tag.tid == model_commit[a]);
      check_tag($sformatf("%s rd%0d tag", name, r), exp_tag, rd_tag_o[r]);
      check_bit($sformatf("%s rd%0d ready", name, r), exp_ready, rd_ready_o[r]);
      check_bit($sformatf("%s rd%0d fwd_lane", name, r),
                exp_ready ? 1'b0 : exp_tag.lane, rd_fwd_lane_o[r]);
    end
    for (int l = 0; l < `SB_ISSUE_W; l++) begin
      check_tag($sformatf("%s wr_tag%0d", name, l),
                issue_tag_t'{tid: model_timer, lane: 1'(l)}, wr_tag_o[l]);
    end
  endtask

  // drive at the rising edge and compare at the falling edge
  task automatic run_cycle(input string name);
    @(posedge clk);
    rd_addr_i <= stim_ra;
    issue_i <= stim_iss;
    wr_addr_i <= stim_wa;
    wb_valid_i <= stim_wbv;
    wb_addr_i <= stim_wba;
    wb_tid_i <= stim_wbt;
    @(negedge clk);
    compare_outputs(name);
    update_model();
  endtask

  task automatic after_reset_state();
    clear_stim();
    for (int c = 0; c < 8; c++) begin
      for (int r = 0; r < `SB_RD_PORTS; r++) begin
        stim_ra[r] = reg_addr_t'(4 * c + r);
      end
      run_cycle("after_reset");
      for (int r = 0; r < `SB_RD_PORTS; r++) begin
        check_tag("after_reset", '0, rd_tag_o[r]);
        check_bit("after_reset", 1'b1, rd_ready_o[r]);
      end
    end
    check_tag("after_reset", issue_tag_t'{tid: tid_t'(1), lane: 1'b0}, wr_tag_o[0]);
    check_tag("after_reset", issue_tag_t'{tid: tid_t'(1), lane: 1'b1}, wr_tag_o[1]);
  endtask

  task automatic issue_marks_pending();
    logic [31:0] rnd;
    reg_addr_t a;
    logic lane;
    issue_tag_t seen;
    rnd = next_random();
    lane = rnd[0];
    a = random_reg();
    clear_stim();
    stim_ra = {`SB_RD_PORTS{a}};
    stim_iss[lane] = 1'b1;
    stim_wa[lane] = a;
    run_cycle("issue_pending");
    seen = wr_tag_o[lane];
    // same-cycle lookup still sees the old entry
    check_bit("issue_pending", 1'b1, rd_ready_o[0]);
    stim_iss = '0;
    run_cycle("issue_pending");
    check_tag("issue_pending", seen, rd_tag_o[0]);
    check_bit("issue_pending", 1'b0, rd_ready_o[0]);
    check_bit("issue_pending", lane, rd_fwd_lane_o[0]);
  endtask

  task automatic timer_advance_wrap();
    tid_t exp_tid;
    clear_stim();
    exp_tid = model_timer;
    stim_iss = 2'b11;
    stim_wa[0] = reg_addr_t'(10);
    stim_wa[1] = reg_addr_t'(11);
    stim_ra[0] = reg_addr_t'(10);
    stim_ra[1] = reg_addr_t'(11);
    run_cycle("timer_wrap");
    // both lanes share one tid
    check_tag("timer_wrap", issue_tag_t'{tid: exp_tid, lane: 1'b0}, wr_tag_o[0]);
    check_tag("timer_wrap", issue_tag_t'{tid: exp_tid, lane: 1'b1}, wr_tag_o[1]);
    stim_iss = '0;
    run_cycle("timer_wrap");
    check_tag("timer_wrap", issue_tag_t'{tid: exp_tid, lane: 1'b0}, rd_tag_o[0]);
    check_tag("timer_wrap", issue_tag_t'{tid: exp_tid, lane: 1'b1}, rd_tag_o[1]);
    // eight back-to-back issues must pass through 7 -> 1
    exp_tid = next_tid(exp_tid);
    for (int c = 0; c < 8; c++) begin
      stim_iss = 2'b01;
      stim_wa[0] = reg_addr_t'(12);
      run_cycle("timer_wrap");
      check_tag("timer_wrap", issue_tag_t'{tid: exp_tid, lane: 1'b0}, wr_tag_o[0]);
      check_bit("timer_wrap", 1'b1, wr_tag_o[0].tid != '0);
      exp_tid = next_tid(exp_tid);
    end
  endtask

  task automatic writeback_clears();
    reg_addr_t a;
    issue_tag_t first;
    issue_tag_t second;
    a = random_reg();
    clear_stim();
    stim_ra = {`SB_RD_PORTS{a}};
    // matching writeback on port 1
    stim_iss[0] = 1'b1;
    stim_wa[0] = a;
    run_cycle("writeback");
    first = wr_tag_o[0];
    stim_iss = '0;
    stim_wbv[1] = 1'b1;
    stim_wba[1] = a;
    stim_wbt[1] = first.tid;
    run_cycle("writeback");
    check_bit("writeback", 1'b0, rd_ready_o[0]);
    stim_wbv = '0;
    run_cycle("writeback");
    check_bit("writeback", 1'b1, rd_ready_o[0]);
    check_bit("writeback", 1'b0, rd_fwd_lane_o[0]);
    // an older tid first and then an overriding second issue
    stim_iss[0] = 1'b1;
    run_cycle("writeback");
    first = wr_tag_o[0];
    stim_iss = '0;
    stim_wbv[0] = 1'b1;
    stim_wba[0] = a;
    stim_wbt[0] = (first.tid == tid_t'(1)) ? tid_t'(7) : tid_t'(first.tid - 1);
    run_cycle("writeback");
    stim_wbv = '0;
    stim_iss[1] = 1'b1;
    stim_wa[1] = a;
    run_cycle("writeback");
    second = wr_tag_o[1];
    check_bit("writeback", 1'b0, rd_ready_o[0]);
    check_tag("writeback", first, rd_tag_o[0]);
    stim_iss = '0;
    stim_wbv[0] = 1'b1;
    stim_wbt[0] = first.tid;
    run_cycle("writeback");
    check_tag("writeback", second, rd_tag_o[0]);
    check_bit("writeback", 1'b1, rd_fwd_lane_o[0]);
    stim_wbv = 2'b10;
    stim_wba[1] = a;
    stim_wbt[1] = second.tid;
    run_cycle("writeback");
    // stale writeback of the first issue left it pending
    check_bit("writeback", 1'b0, rd_ready_o[0]);
    stim_wbv = '0;
    run_cycle("writeback");
    check_bit("writeback", 1'b1, rd_ready_o[0]);
    check_bit("writeback", 1'b0, rd_fwd_lane_o[0]);
  endtask

  task automatic reg_zero_untracked();
    clear_stim();
    stim_iss = 2'b11;
    stim_wbv = 2'b11;
    stim_wbt = {tid_t'(5), tid_t'(5)};
    run_cycle("reg_zero");
    clear_stim();
    run_cycle("reg_zero");
    for (int r = 0; r < `SB_RD_PORTS; r++) begin
      check_tag("reg_zero", '0, rd_tag_o[r]);
      check_bit("reg_zero", 1'b1, rd_ready_o[r]);
      check_bit("reg_zero", 1'b0, rd_fwd_lane_o[r]);
    end
  endtask

  task automatic random_mix();
    logic [31:0] rnd;
    for (int c = 0; c < 200; c++) begin
      rnd = next_random();
      stim_iss = rnd[1:0];
      stim_wbv = rnd[3:2];
      // low registers only so that issues and writebacks meet often
      for (int p = 0; p < `SB_ISSUE_W; p++) begin
        stim_wa[p] = reg_addr_t'(next_random() % 8);
        stim_wba[p] = reg_addr_t'(next_random() % 8);
        rnd = next_random();
        if (rnd[0]) begin
          stim_wbt[p] = model_issue[stim_wba[p]].tid;
        end else begin
          stim_wbt[p] = tid_t'(1 + rnd[8:1] % 7);
        end
      end
      for (int r = 0; r < `SB_RD_PORTS; r++) begin
        stim_ra[r] = reg_addr_t'(next_random() % 8);
      end
      run_cycle("random_mix");
    end
  endtask

  initial begin
    clear_stim();
    reset_model();
    rst_n = 1'b0;
    rd_addr_i = '0;
    issue_i = '0;
    wr_addr_i = '0;
    wb_addr_i = '0;
    wb_tid_i = '0;
    wb_valid_i = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    after_reset_state();
    issue_marks_pending();
    timer_advance_wrap();
    writeback_clears();
    reg_zero_untracked();
    random_mix();
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sb_top.sv
/*
  Top level of the register scoreboard.
  Plain ports on the outside; inside, the issue bundle and the
  writeback ports travel as interfaces between allocator, boards and
  status logic. Lookups are combinational, issues and writebacks show
  up from the next cycle. The block never stalls.
*/
`timescale 1ns/1ns
`default_nettype none

`include "sb_defs.svh"

module sb_top import sb_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  // operand lookups
  input  reg_addr_t  [`SB_RD_PORTS-1:0] rd_addr_i,
  // issue
  input  logic       [`SB_ISSUE_W-1:0]  issue_i,
  input  reg_addr_t  [`SB_ISSUE_W-1:0]  wr_addr_i,
  output issue_tag_t [`SB_ISSUE_W-1:0]  wr_tag_o,
  // writeback
  input  reg_addr_t  [`SB_ISSUE_W-1:0]  wb_addr_i,
  input  tid_t       [`SB_ISSUE_W-1:0]  wb_tid_i,
  input  logic       [`SB_ISSUE_W-1:0]  wb_valid_i,
  // operand status
  output issue_tag_t [`SB_RD_PORTS-1:0] rd_tag_o,
  output logic       [`SB_RD_PORTS-1:0] rd_ready_o,
  output logic       [`SB_RD_PORTS-1:0] rd_fwd_lane_o
);

  issue_port_if issue_if ();
  wb_port_if wb_if ();

  tid_t [`SB_RD_PORTS-1:0] commit_tid;

  // outside world into the interfaces
  assign issue_if.rd_addr = rd_addr_i;
  assign issue_if.issue = issue_i;
  assign issue_if.wr_addr = wr_addr_i;
  assign wr_tag_o = issue_if.wr_tag;

  assign wb_if.wb_addr = wb_addr_i;
  assign wb_if.wb_tid = wb_tid_i;
  assign wb_if.wb_valid = wb_valid_i;

  issue_alloc u_issue_alloc (
    .clk   (clk),
    .rst_n (rst_n),
    .ports (issue_if.alloc)
  );

  scoreboard u_scoreboard (
    .clk          (clk),
    .rst_n        (rst_n),
    .ports        (issue_if.board),
    .wb           (wb_if.board),
    .issue_tag_o  (rd_tag_o),
    .commit_tid_o (commit_tid)
  );

  operand_status u_operand_status (
    .issue_tag_i  (rd_tag_o),
    .commit_tid_i (commit_tid),
    .ready_o      (rd_ready_o),
    .fwd_lane_o   (rd_fwd_lane_o)
  );

endmodule

`default_nettype wire

// File: operand_status.sv
/*
  Output side of the scoreboard.
  For each source operand, compares the timer part of its issue tag
  with the commit board entry. A match means the value is in the
  register file; otherwise the lane bit of the tag names the pipeline
  that will forward it.
*/
`timescale 1ns/1ns
`default_nettype none

`include "sb_defs.svh"

module operand_status import sb_pkg::*; (
  input  issue_tag_t [`SB_RD_PORTS-1:0] issue_tag_i,
  input  tid_t       [`SB_RD_PORTS-1:0] commit_tid_i,
  output logic       [`SB_RD_PORTS-1:0] ready_o,
  output logic       [`SB_RD_PORTS-1:0] fwd_lane_o
);

  always_comb begin
    for (int r = 0; r < `SB_RD_PORTS; r++) begin
      // latest writer already written back
      ready_o[r] = (issue_tag_i[r].tid == commit_tid_i[r]);
      // lane only means something while pending
      if (ready_o[r]) begin
        fwd_lane_o[r] = 1'b0;
      end else begin
        fwd_lane_o[r] = issue_tag_i[r].lane;
      end
    end
  end

endmodule

`default_nettype wire

// File: scoreboard.sv
/*
  Processing part of the scoreboard.
  The issue board keeps the tag of the latest writer of each register,
  the commit board the timer of the latest writeback. Both are looked
  up with the same four source addresses and the raw entries go to the
  status logic. Lookups are combinational, writes land at the next edge.
*/
`timescale 1ns/1ns
`default_nettype none

`include "sb_defs.svh"

module scoreboard import sb_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  issue_port_if.board ports,
  wb_port_if.board wb,
  output issue_tag_t [`SB_RD_PORTS-1:0] issue_tag_o,
  output tid_t       [`SB_RD_PORTS-1:0] commit_tid_o
);

  // writeback to register 0 is dropped
  for (genvar p = 0; p < `SB_ISSUE_W; p++) begin : g_wb_en
    assign wb.wb_en[p] = wb.wb_valid[p] && (wb.wb_addr[p] != '0);
  end

  // tag of the latest issued writer
  regfile_4r2w #(
    .payload_t (issue_tag_t)
  ) issue_board (
    .clk   (clk),
    .rst_n (rst_n),
    .ra_i  (ports.rd_addr),
    .rd_o  (issue_tag_o),
    .wa_i  (ports.wr_addr),
    .wd_i  (ports.wr_tag),
    .we_i  (ports.wr_en)
  );

  // timer of the latest writeback
  regfile_4r2w #(
    .payload_t (tid_t)
  ) commit_board (
    .clk   (clk),
    .rst_n (rst_n),
    .ra_i  (ports.rd_addr),
    .rd_o  (commit_tid_o),
    .wa_i  (wb.wb_addr),
    .wd_i  (wb.wb_tid),
    .we_i  (wb.wb_en)
  );

endmodule

`default_nettype wire

// File: regfile_4r2w.sv
/*
  Small register file with four combinational read ports and two
  write ports, written at the rising clock.
  The payload type is a parameter so the same block holds issue tags
  or commit timers. All entries clear to zero at reset. On a write
  collision to one address, port 1 wins.
*/
`timescale 1ns/1ns
`default_nettype none

`include "sb_defs.svh"

module regfile_4r2w import sb_pkg::*; #(
  parameter type payload_t = logic [3:0]
) (
  input  logic clk,
  input  logic rst_n,
  // read side
  input  reg_addr_t [`SB_RD_PORTS-1:0] ra_i,
  output payload_t  [`SB_RD_PORTS-1:0] rd_o,
  // write side
  input  reg_addr_t [`SB_ISSUE_W-1:0] wa_i,
  input  payload_t  [`SB_ISSUE_W-1:0] wd_i,
  input  logic      [`SB_ISSUE_W-1:0] we_i
);

  payload_t [`SB_NUM_REGS-1:0] mem_q;

  // reads see the old entry during a same-cycle write
  for (genvar r = 0; r < `SB_RD_PORTS; r++) begin : g_rd
    assign rd_o[r] = mem_q[ra_i[r]];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `SB_NUM_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      // ascending order so the higher port lands last
      for (int w = 0; w < `SB_ISSUE_W; w++) begin
        if (we_i[w]) begin
          mem_q[wa_i[w]] <= wd_i[w];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: issue_alloc.sv
/*
  Issue side of the scoreboard.
  Keeps the single issue timer shared by both lanes and turns each
  issue into a tag {timer, lane} plus a write enable for the issue
  board. The timer counts 1..7 and never shows 0, which is reserved
  for operands that need no forwarding.
*/
`timescale 1ns/1ns
`default_nettype none

`include "sb_defs.svh"

module issue_alloc import sb_pkg::*; (
  input logic clk,
  input logic rst_n,
  issue_port_if.alloc ports
);

  tid_t timer_q;
  tid_t timer_d;

  // advance on any issue, 7 wraps back to 1
  always_comb begin
    timer_d = timer_q;
    if (|ports.issue) begin
      if (timer_q == '1) begin
        timer_d = tid_t'(1);
      end else begin
        timer_d = timer_q + tid_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer_q <= tid_t'(1);
    end else begin
      timer_q <= timer_d;
    end
  end

  // both lanes share this cycle's timer and differ only in lane
  for (genvar l = 0; l < `SB_ISSUE_W; l++) begin : g_lane
    assign ports.wr_tag[l].tid = timer_q;
    assign ports.wr_tag[l].lane = 1'(l);
    // register 0 is hardwired, never tracked
    assign ports.wr_en[l] = ports.issue[l] && (ports.wr_addr[l] != '0);
  end

endmodule

`default_nettype wire

// File: wb_port_if.sv
/*
  Writeback ports into the commit board.
  The source side drives address, timer and valid; the board forms
  its own write enables with register 0 masked.
*/
`timescale 1ns/1ns
`default_nettype none

`include "sb_defs.svh"

interface wb_port_if import sb_pkg::*; ();

  reg_addr_t [`SB_ISSUE_W-1:0] wb_addr;
  tid_t [`SB_ISSUE_W-1:0] wb_tid;
  logic [`SB_ISSUE_W-1:0] wb_valid;
  logic [`SB_ISSUE_W-1:0] wb_en;

  modport src (
    output wb_addr,
    output wb_tid,
    output wb_valid
  );

  modport board (
    input  wb_addr,
    input  wb_tid,
    input  wb_valid,
    output wb_en
  );

endinterface

`default_nettype wire

// File: issue_port_if.sv
/*
  Issue bundle between the allocator and the scoreboard.
  The top level drives the read addresses, issue strobes and write
  addresses; the allocator adds the tags and the masked write enables.
  All strobes are single-cycle levels, there is no handshake.
*/
`timescale 1ns/1ns
`default_nettype none

`include "sb_defs.svh"

interface issue_port_if import sb_pkg::*; ();

  // source operand lookups, straight from the top
  reg_addr_t [`SB_RD_PORTS-1:0] rd_addr;

  // per-lane issue
  logic [`SB_ISSUE_W-1:0] issue;
  reg_addr_t [`SB_ISSUE_W-1:0] wr_addr;
  issue_tag_t [`SB_ISSUE_W-1:0] wr_tag;
  // issue with register 0 masked off
  logic [`SB_ISSUE_W-1:0] wr_en;

  modport alloc (
    input  issue,
    input  wr_addr,
    output wr_tag,
    output wr_en
  );

  modport board (
    input rd_addr,
    input issue,
    input wr_addr,
    input wr_tag,
    input wr_en
  );

endinterface

`default_nettype wire

// File: sb_pkg.sv
/*
  Types shared by the scoreboard blocks and the testbench.
  Import with a wildcard in the module header; sizes come from the
  macros in sb_defs.svh.
*/
`default_nettype none

`include "sb_defs.svh"

package sb_pkg;

  // architectural register number
  typedef logic [`SB_REG_ADDR_W-1:0] reg_addr_t;

  // issue timer value
  // 0 never comes out of the allocator and means data ready
  typedef logic [`SB_TID_W-1:0] tid_t;

  // tag handed to each issued instruction
  // lane is the low bit, so the tag reads as {tid, lane}
  typedef struct packed {
    tid_t tid;
    logic lane;
  } issue_tag_t;

endpackage

`default_nettype wire

// File: sb_defs.svh
/*
  Sizing macros for the register scoreboard.
  Include this wherever a port width or array depth is needed; the
  type definitions built on these live in sb_pkg.
*/
`ifndef SB_DEFS_SVH
`define SB_DEFS_SVH

// architectural register file
`define SB_NUM_REGS 32
`define SB_REG_ADDR_W 5

// shared issue timer, value 0 is the "ready" tag
`define SB_TID_W 3

// source operand lookups per cycle
`define SB_RD_PORTS 4

// issue lanes, also the number of writeback ports
`define SB_ISSUE_W 2

`endif
